/* verilog.f */
hw/mem_pkg.sv
hw/rom_slot.sv
hw/slot_arbiter.sv
hw/rom_loader.sv
hw/header_regs.sv
hw/game_sdram.sv
dv/sdram_bank_model.sv
dv/tb_game_sdram.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_game_sdram
RTL_TOP   := game_sdram
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/tb_game_sdram.sv */
//**************************************************************************
// Downloads a sparse image, 128 bytes at the start of each region, with
// strobes 8 cycles apart. Reads stay inside the downloaded bytes
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_game_sdram
    import mem_pkg::*;
;

    localparam int n_dl       = 4;
    localparam int blk_len    = 128;                 // Bytes per region
    localparam int snd_base   = 2 * int'(snd_offset); // Payload byte of sound ROM
    localparam int n_main     = 24;
    localparam int n_snd      = 24;
    localparam int n_pair     = 8;
    localparam int read_limit = 100;
    localparam int wd_cycles  = n_dl * (header_len + 2 * blk_len) * 8
                              + (n_main + n_snd + n_pair) * 2000 + 200;

    logic clk, rst_n;
    logic main_cs, main_ok, snd_cs, snd_ok;
    logic [main_aw-1:0] main_addr;
    logic [snd_aw-1:0] snd_addr;
    main_data_t main_data;
    snd_data_t snd_data;
    logic downloading, ioctl_wr, dwnld_busy, dec_en, dec_type;
    logic [ioctl_aw-1:0] ioctl_addr;
    logic [7:0] ioctl_dout, game_id;
    logic ba_rd, ba_ack, ba_rdy, prog_we, prog_ack;
    bank_addr_t ba_addr, prog_addr;
    bank_word_t data_read, prog_data;
    logic [1:0] prog_mask;

    logic [7:0] img [int];  // Payload bytes as sent by payload offset
    logic [31:0] lfsr = 32'd67740;
    int data_errs = 0;
    int cfg_errs = 0;
    int proto_errs = 0;
    int rd_count = 0;

    game_sdram uut (
        .clk ( clk ), .rst_n ( rst_n ),
        .main_cs ( main_cs ), .main_addr ( main_addr ), .main_data ( main_data ),
        .main_ok ( main_ok ),
        .snd_cs ( snd_cs ), .snd_addr ( snd_addr ), .snd_data ( snd_data ), .snd_ok ( snd_ok ),
        .downloading ( downloading ), .ioctl_addr ( ioctl_addr ), .ioctl_dout ( ioctl_dout ),
        .ioctl_wr ( ioctl_wr ), .dwnld_busy ( dwnld_busy ),
        .game_id ( game_id ), .dec_en ( dec_en ), .dec_type ( dec_type ),
        .ba_rd ( ba_rd ), .ba_addr ( ba_addr ), .ba_ack ( ba_ack ), .ba_rdy ( ba_rdy ),
        .data_read ( data_read ), .prog_we ( prog_we ), .prog_addr ( prog_addr ),
        .prog_data ( prog_data ), .prog_mask ( prog_mask ), .prog_ack ( prog_ack )
    );

    sdram_bank_model u_bank (
        .clk ( clk ), .rst_n ( rst_n ),
        .ba_rd ( ba_rd ), .ba_addr ( ba_addr ), .ba_ack ( ba_ack ), .ba_rdy ( ba_rdy ),
        .data_read ( data_read ), .prog_we ( prog_we ), .prog_addr ( prog_addr ),
        .prog_data ( prog_data ), .prog_mask ( prog_mask ), .prog_ack ( prog_ack )
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        logic        b;
        int          k;
        r = '0;
        for (k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    // Even payload byte is the low half of the word
    function automatic bank_word_t ref_word(input bank_addr_t w);
        int off;
        off = 2 * int'(w);
        return {img[off + 1], img[off]};
    endfunction

    function automatic snd_data_t ref_snd(input logic [snd_aw-1:0] s);
        bank_word_t w;
        w = ref_word(snd_offset + bank_addr_t'(s >> 1));
        return s[0] ? w[15:8] : w[7:0];
    endfunction

    function automatic logic ref_dec_en(input logic [7:0] v);
        return (v[1:0] != 2'b00) || v[2];
    endfunction

    task automatic check_main(input logic [main_aw-1:0] a, input main_data_t got,
                              input main_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("[FAIL] main_data at %h: got %h, expected %h", a, got, exp);
        end
    endtask

    task automatic check_snd(input logic [snd_aw-1:0] a, input snd_data_t got,
                             input snd_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("[FAIL] snd_data at %h: got %h, expected %h", a, got, exp);
        end
    endtask

    task automatic check_word(input bank_addr_t w, input bank_word_t got, input bank_word_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("[FAIL] u_bank.mem[%h]: got %h, expected %h", w, got, exp);
        end
    endtask

    task automatic check_cfg(input logic [7:0] id, input logic en, input logic typ,
                             input logic [7:0] exp_id, input logic exp_en, input logic exp_typ);
        if (id !== exp_id || en !== exp_en || typ !== exp_typ) begin
            cfg_errs++;
            $display("[FAIL] game_id/dec_en/dec_type: got %h/%h/%h, expected %h/%h/%h",
                     id, en, typ, exp_id, exp_en, exp_typ);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            proto_errs++;
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Any cycle with ok high must show the reference data
    always @(negedge clk) begin
        if (rst_n && main_ok)
            check_main(main_addr, main_data, main_data_t'(ref_word(bank_addr_t'(main_addr))));
        if (rst_n && snd_ok) check_snd(snd_addr, snd_data, ref_snd(snd_addr));
        if (ba_rd && ba_ack) rd_count++;
    end

    task automatic send_byte(input int a, input logic [7:0] d);
        @(posedge clk);
        #5;
        ioctl_addr = ioctl_aw'(a);
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #5 ioctl_wr = 1'b0;
        repeat (6) @(posedge clk);  // 8 cycles between strobes
    endtask

    task automatic send_payload(input int off);
        logic [7:0] b;
        b        = 8'(take_bits(8));
        img[off] = b;
        send_byte(header_len + off, b);
    endtask

    task automatic download(input logic [7:0] dec_val);
        logic [7:0] hdr [header_len];
        logic [7:0] id;
        int         i;
        int         n;
        for (i = 0; i < header_len; i++) hdr[i] = 8'(take_bits(8));
        id                = hdr[hdr_id_addr];
        hdr[hdr_dec_addr] = dec_val;
        @(posedge clk);
        #5 downloading = 1'b1;
        for (i = 0; i < header_len; i++) send_byte(i, hdr[i]);
        @(negedge clk);
        check_cfg(game_id, dec_en, dec_type, id, ref_dec_en(dec_val), dec_val[1]);
        for (i = 0; i < blk_len; i++) send_payload(i);
        for (i = 0; i < blk_len; i++) send_payload(snd_base + i);
        @(posedge clk);
        #5 downloading = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (dwnld_busy && n < read_limit);
        if (dwnld_busy) begin
            proto_errs++;
            $display("dwnld_busy still high %0d cycles after the download ended", n);
        end
        for (i = 0; i < blk_len / 2; i++) begin
            check_word(bank_addr_t'(i), u_bank.mem[bank_addr_t'(i)], ref_word(bank_addr_t'(i)));
            check_word(snd_offset + bank_addr_t'(i), u_bank.mem[snd_offset + bank_addr_t'(i)],
                       ref_word(snd_offset + bank_addr_t'(i)));
        end
    endtask

    // Hold cs on the chosen slots until every one of them shows ok
    task automatic fetch(input logic do_main, input logic do_snd,
                         input logic [main_aw-1:0] ma, input logic [snd_aw-1:0] sa);
        int n;
        @(posedge clk);
        #5;
        main_cs   = do_main;
        snd_cs    = do_snd;
        main_addr = ma;
        snd_addr  = sa;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (((do_main && !main_ok) || (do_snd && !snd_ok)) && n < read_limit);
        if ((do_main && !main_ok) || (do_snd && !snd_ok)) begin
            proto_errs++;
            $display("Read of main %h / sound %h never completed", ma, sa);
        end
        @(posedge clk);
        #5;
        main_cs = 1'b0;
        snd_cs  = 1'b0;
    endtask

    initial begin
        logic [7:0]         dec_vals [n_dl];
        logic [main_aw-1:0] ma;
        logic [snd_aw-1:0]  sa;
        int                 i;
        int                 rd_before;
        dec_vals    = '{8'h02, 8'h04, 8'h00, 8'h01};  // Each value changes the flags
        rst_n       = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        repeat (8) @(posedge clk);
        #5 rst_n = 1'b1;
        @(negedge clk);
        check_bit("ba_rd", ba_rd, 1'b0);
        check_bit("prog_we", prog_we, 1'b0);
        check_bit("main_ok", main_ok, 1'b0);
        check_bit("snd_ok", snd_ok, 1'b0);
        check_cfg(game_id, dec_en, dec_type, 8'h00, 1'b0, 1'b0);

        for (i = 0; i < n_dl; i++) download(dec_vals[i]);
        for (i = 0; i < n_main; i++) fetch(1'b1, 1'b0, main_aw'(take_bits(6)), '0);
        for (i = 0; i < n_snd; i++) fetch(1'b0, 1'b1, '0, snd_aw'(take_bits(7)));

        for (i = 0; i < n_pair; i++) begin
            ma = main_aw'(take_bits(6));
            sa = snd_aw'(take_bits(7));
            fetch(1'b1, 1'b1, ma, sa);
            rd_before = rd_count;
            @(posedge clk);
            #5;
            main_cs = 1'b1;  // Same addresses again are served from the slots
            snd_cs  = 1'b1;
            repeat (10) begin
                @(negedge clk);
                check_bit("main_ok", main_ok, 1'b1);
                check_bit("snd_ok", snd_ok, 1'b1);
            end
            @(posedge clk);
            #5;
            main_cs = 1'b0;
            snd_cs  = 1'b0;
            if (rd_count != rd_before) begin
                proto_errs++;
                $display("Repeated main %h / sound %h caused a new bank read", ma, sa);
            end
        end

        repeat (4) @(posedge clk);
        $display("Errors: data %0d, config %0d, protocol %0d", data_errs, cfg_errs, proto_errs);
        if (data_errs + cfg_errs + proto_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(wd_cycles * 40);
        $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/sdram_bank_model.sv */
//**************************************************************************
// Single bank stand-in with 1 to 4 cycle waits on both ports. Words never
// written read back a pattern of their whole address
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module sdram_bank_model
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ba_rd,
    input  bank_addr_t ba_addr,
    output logic       ba_ack,
    output logic       ba_rdy,
    output bank_word_t data_read,
    input  logic       prog_we,
    input  bank_addr_t prog_addr,
    input  bank_word_t prog_data,
    input  logic [1:0] prog_mask,
    output logic       prog_ack
);

    bank_word_t mem [bank_addr_t];  // Holds written words only
    bank_addr_t rd_addr;
    logic [1:0] lat;       // Free-running wait source
    logic [1:0] rd_wait;
    logic [1:0] wr_wait;
    logic       rd_phase;  // Read acked and data still to come

    function automatic bank_word_t peek(input bank_addr_t a);
        if (mem.exists(a)) return mem[a];
        return a[15:0] ^ {a[21:16], a[21:12]} ^ 16'h5a3c;
    endfunction

    // One active low mask bit per byte
    function automatic bank_word_t merge(input bank_word_t old, input bank_word_t nw,
                                         input logic [1:0] mask);
        bank_word_t m;
        m = old;
        if (!mask[0]) m[7:0] = nw[7:0];
        if (!mask[1]) m[15:8] = nw[15:8];
        return m;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat       <= 2'd0;
            ba_ack    <= 1'b0;
            ba_rdy    <= 1'b0;
            prog_ack  <= 1'b0;
            rd_phase  <= 1'b0;
            rd_wait   <= 2'd0;
            wr_wait   <= 2'd0;
            rd_addr   <= '0;
            data_read <= '0;
        end else begin
            lat      <= lat + 2'd1;
            ba_ack   <= 1'b0;
            ba_rdy   <= 1'b0;
            prog_ack <= 1'b0;
            if (rd_phase) begin
                if (rd_wait == 2'd0) begin
                    ba_rdy    <= 1'b1;
                    data_read <= peek(rd_addr);
                    rd_phase  <= 1'b0;
                    rd_wait   <= lat;
                end else rd_wait <= rd_wait - 2'd1;
            end else if (!ba_rd) begin
                rd_wait <= lat;
            end else if (rd_wait == 2'd0) begin
                ba_ack   <= 1'b1;  // Data follows at least a cycle later
                rd_addr  <= ba_addr;
                rd_phase <= 1'b1;
                rd_wait  <= lat;
            end else rd_wait <= rd_wait - 2'd1;

            if (!prog_we || prog_ack) begin
                wr_wait <= lat;
            end else if (wr_wait == 2'd0) begin
                mem[prog_addr] = merge(peek(prog_addr), prog_data, prog_mask);
                prog_ack <= 1'b1;
            end else wr_wait <= wr_wait - 2'd1;
        end
    end

endmodule

`default_nettype wire

/* hw/game_sdram.sv */
//**************************************************************************
// Memory map top. Main CPU and sound CPU share one bank read port, and the
// download writes the same bank through a separate write port
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module game_sdram
    import mem_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                main_cs,
    input  logic [main_aw-1:0]  main_addr,
    output main_data_t          main_data,
    output logic                main_ok,
    input  logic                snd_cs,
    input  logic [snd_aw-1:0]   snd_addr,
    output snd_data_t           snd_data,
    output logic                snd_ok,
    input  logic                downloading,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    output logic                dwnld_busy,
    output logic [7:0]          game_id,
    output logic                dec_en,
    output logic                dec_type,
    output logic                ba_rd,
    output bank_addr_t          ba_addr,
    input  logic                ba_ack,
    input  logic                ba_rdy,
    input  bank_word_t          data_read,
    output logic                prog_we,
    output bank_addr_t          prog_addr,
    output bank_word_t          prog_data,
    output logic [1:0]          prog_mask,
    input  logic                prog_ack
);

    logic              main_req, main_ack, main_rdy;
    logic              snd_req, snd_ack, snd_rdy;
    bank_addr_t        main_baddr, snd_baddr;
    logic              hdr_wr;
    logic [hdr_aw-1:0] hdr_addr;
    logic [7:0]        hdr_data;

    rom_slot #(
        .slot_data_t   ( main_data_t ),
        .addr_w        ( main_aw     ),
        .region_offset ( '0          )
    ) u_main (
        .clk ( clk ), .rst_n ( rst_n ), .cs ( main_cs ), .addr ( main_addr ),
        .data ( main_data ), .ok ( main_ok ),
        .slot_req ( main_req ), .slot_addr ( main_baddr ), .slot_ack ( main_ack ),
        .slot_rdy ( main_rdy ), .bank_data ( data_read )
    );

    rom_slot #(
        .slot_data_t   ( snd_data_t ),
        .addr_w        ( snd_aw     ),
        .region_offset ( snd_offset )
    ) u_snd (
        .clk ( clk ), .rst_n ( rst_n ), .cs ( snd_cs ), .addr ( snd_addr ),
        .data ( snd_data ), .ok ( snd_ok ),
        .slot_req ( snd_req ), .slot_addr ( snd_baddr ), .slot_ack ( snd_ack ),
        .slot_rdy ( snd_rdy ), .bank_data ( data_read )
    );

    slot_arbiter u_arb (
        .clk ( clk ), .rst_n ( rst_n ), .downloading ( downloading ),
        .req0 ( main_req ), .req1 ( snd_req ), .addr0 ( main_baddr ), .addr1 ( snd_baddr ),
        .ack0 ( main_ack ), .ack1 ( snd_ack ), .rdy0 ( main_rdy ), .rdy1 ( snd_rdy ),
        .ba_rd ( ba_rd ), .ba_addr ( ba_addr ), .ba_ack ( ba_ack ), .ba_rdy ( ba_rdy )
    );

    rom_loader u_loader (
        .clk ( clk ), .rst_n ( rst_n ), .downloading ( downloading ),
        .ioctl_addr ( ioctl_addr ), .ioctl_dout ( ioctl_dout ), .ioctl_wr ( ioctl_wr ),
        .hdr_wr ( hdr_wr ), .hdr_addr ( hdr_addr ), .hdr_data ( hdr_data ),
        .prog_we ( prog_we ), .prog_addr ( prog_addr ), .prog_data ( prog_data ),
        .prog_mask ( prog_mask ), .prog_ack ( prog_ack ), .dwnld_busy ( dwnld_busy )
    );

    header_regs u_hdr (
        .clk ( clk ), .rst_n ( rst_n ),
        .hdr_wr ( hdr_wr ), .hdr_addr ( hdr_addr ), .hdr_data ( hdr_data ),
        .game_id ( game_id ), .dec_en ( dec_en ), .dec_type ( dec_type )
    );

endmodule

`default_nettype wire

/* hw/header_regs.sv */
//**************************************************************************
// Game configuration taken from the download header
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module header_regs
    import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              hdr_wr,
    input  logic [hdr_aw-1:0] hdr_addr,
    input  logic [7:0]        hdr_data,
    output logic [7:0]        game_id,
    output logic              dec_en,
    output logic              dec_type
);

    logic dec0_flag;  // First decoder type
    logic dec1_flag;  // Second decoder type

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            game_id   <= 8'd0;
            dec_type  <= 1'b0;
            dec0_flag <= 1'b0;
            dec1_flag <= 1'b0;
            dec_en    <= 1'b0;
        end else begin
            if (hdr_wr && hdr_addr == hdr_dec_addr) begin
                dec0_flag <= |hdr_data[1:0];
                dec_type  <= hdr_data[1];
                dec1_flag <= hdr_data[2];
            end
            if (hdr_wr && hdr_addr == hdr_id_addr) game_id <= hdr_data;
            dec_en <= dec0_flag | dec1_flag;  // One cycle behind the flags
        end
    end

endmodule

`default_nettype wire

/* hw/rom_loader.sv */
//**************************************************************************
// Download packer. Strobes must be at least 8 cycles apart since there is
// no back-pressure. A trailing odd byte is written with the top half masked
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module rom_loader
    import mem_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                downloading,
    input  logic [ioctl_aw-1:0] ioctl_addr,
    input  logic [7:0]          ioctl_dout,
    input  logic                ioctl_wr,
    output logic                hdr_wr,
    output logic [hdr_aw-1:0]   hdr_addr,
    output logic [7:0]          hdr_data,
    output logic                prog_we,
    output bank_addr_t          prog_addr,
    output bank_word_t          prog_data,
    output logic [1:0]          prog_mask,
    input  logic                prog_ack,
    output logic                dwnld_busy
);

    logic [ioctl_aw-1:0] pay_off;
    logic                is_hdr;
    logic                pay_wr;
    logic                tail_wr;
    logic                start_wr;
    logic [7:0]          low_byte;
    bank_addr_t          low_addr;
    logic                low_valid;
    logic                downloading_l;

    assign is_hdr   = ioctl_addr < ioctl_aw'(header_len);
    assign pay_off  = ioctl_addr - ioctl_aw'(header_len);
    assign pay_wr   = downloading && ioctl_wr && !is_hdr;
    assign tail_wr  = downloading_l && !downloading && low_valid;  // Odd-length image
    assign start_wr = (pay_wr && pay_off[0]) || tail_wr;

    assign hdr_wr     = downloading && ioctl_wr && is_hdr;
    assign hdr_addr   = ioctl_addr[hdr_aw-1:0];
    assign hdr_data   = ioctl_dout;
    assign dwnld_busy = downloading | prog_we | low_valid;  // Held tail byte is still owed

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we       <= 1'b0;
            low_valid     <= 1'b0;
            downloading_l <= 1'b0;
        end else begin
            downloading_l <= downloading;
            if (prog_ack) prog_we <= 1'b0;
            if (start_wr) prog_we <= 1'b1;
            if (pay_wr) low_valid <= !pay_off[0];
            else if (tail_wr) low_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (pay_wr && !pay_off[0]) begin
            low_byte <= ioctl_dout;
            low_addr <= bank_addr_t'(pay_off >> 1);
        end
        if (pay_wr && pay_off[0]) begin
            prog_addr <= bank_addr_t'(pay_off >> 1);
            prog_data <= {ioctl_dout, low_byte};
            prog_mask <= 2'b00;
        end else if (tail_wr) begin
            prog_addr <= low_addr;
            prog_data <= {8'h00, low_byte};
            prog_mask <= 2'b10;  // Upper byte left alone
        end
    end

    // Relies on the stream spacing and the bank write latency
    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        start_wr |-> !prog_we || prog_ack)
        else $error("bank write started while another is pending");

endmodule

`default_nettype wire

/* hw/slot_arbiter.sv */
//**************************************************************************
// Round-robin owner of the bank read port, one read in flight at a time.
// No new read starts while the download is running
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module slot_arbiter
    import mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       downloading,
    input  logic       req0,
    input  logic       req1,
    input  bank_addr_t addr0,
    input  bank_addr_t addr1,
    output logic       ack0,
    output logic       ack1,
    output logic       rdy0,
    output logic       rdy1,
    output logic       ba_rd,
    output bank_addr_t ba_addr,
    input  logic       ba_ack,
    input  logic       ba_rdy
);

    typedef enum logic {st_idle, st_busy} arb_state_t;

    arb_state_t state;
    logic       last;   // Slot served last
    logic       owner;  // Slot of the read in flight
    logic       pick;
    logic       grant;

    always_comb begin
        if (req0 && req1) pick = ~last;  // Take turns when both wait
        else              pick = req1;
    end

    assign grant = state == st_idle && !downloading && (req0 || req1);

    // Ack and ready go back only to the owner
    assign ack0 = ba_rd && ba_ack && !owner;
    assign ack1 = ba_rd && ba_ack && owner;
    assign rdy0 = state == st_busy && ba_rdy && !owner;
    assign rdy1 = state == st_busy && ba_rdy && owner;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            last  <= 1'b1;
            owner <= 1'b0;
            ba_rd <= 1'b0;
        end else if (grant) begin
            state <= st_busy;
            owner <= pick;
            last  <= pick;
            ba_rd <= 1'b1;
        end else if (state == st_busy) begin
            if (ba_ack) ba_rd <= 1'b0;
            if (ba_rdy) state <= st_idle;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) ba_addr <= pick ? addr1 : addr0;
    end

    a_no_stray_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        state == st_idle |-> !ba_rdy)
        else $error("ba_rdy with no read in flight");

endmodule

`default_nettype wire

/* hw/rom_slot.sv */
//**************************************************************************
// Cached read slot holding one bank word. An 8-bit payload takes the byte
// picked by addr[0], low byte first. The client must hold addr while cs
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module rom_slot
    import mem_pkg::*;
#(
    parameter type               slot_data_t   = main_data_t,
    parameter int                addr_w        = main_aw,
    parameter bank_addr_t        region_offset = '0
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cs,
    input  logic [addr_w-1:0] addr,
    output slot_data_t        data,
    output logic              ok,
    output logic              slot_req,
    output bank_addr_t        slot_addr,
    input  logic              slot_ack,
    input  logic              slot_rdy,
    input  bank_word_t        bank_data
);

    typedef enum logic [1:0] {st_idle, st_req, st_wait} slot_state_t;

    localparam bit is_byte = $bits(slot_data_t) == 8;

    slot_state_t state;
    bank_addr_t  word_addr;
    bank_addr_t  req_addr;
    bank_addr_t  tag;
    bank_word_t  cached_word;
    bank_word_t  shifted;
    logic        valid;
    logic        hit;

    // Byte slots address half words
    assign word_addr = (is_byte ? bank_addr_t'(addr >> 1) : bank_addr_t'(addr)) + region_offset;
    assign hit       = valid && tag == word_addr;
    assign ok        = cs && hit;
    assign shifted   = (is_byte && addr[0]) ? (cached_word >> 8) : cached_word;
    assign data      = slot_data_t'(shifted);
    assign slot_req  = state == st_req;
    assign slot_addr = req_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            valid <= 1'b0;
        end else begin
            case (state)
                st_idle: if (cs && !hit) state <= st_req;
                st_req:  if (slot_ack) state <= st_wait;
                st_wait: if (slot_rdy) begin
                    state <= st_idle;
                    valid <= 1'b1;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cs && !hit) req_addr <= word_addr;  // Latch on miss
        if (state == st_wait && slot_rdy) begin
            tag         <= req_addr;
            cached_word <= bank_data;
        end
    end

    // The arbiter may sit on a request for many cycles
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        slot_req && !slot_ack |=> $stable(slot_addr))
        else $error("slot_addr changed before slot_ack");

endmodule

`default_nettype wire

/* hw/mem_pkg.sv */
//**************************************************************************
// Single SDRAM bank memory map. The sound region sits at a fixed word offset
// and the download header is 32 bytes long
//**************************************************************************
`default_nettype none

package mem_pkg;

    localparam int bank_aw  = 22;  // Word address into the bank
    localparam int bank_dw  = 16;
    localparam int main_aw  = 18;  // Main CPU word address
    localparam int snd_aw   = 15;  // Sound CPU byte address
    localparam int ioctl_aw = 25;  // Download byte address
    localparam int hdr_aw   = 5;

    typedef logic [15:0]        main_data_t;
    typedef logic [7:0]         snd_data_t;
    typedef logic [bank_dw-1:0] bank_word_t;
    typedef logic [bank_aw-1:0] bank_addr_t;

    // Sound ROM starts 256 kB into the bank
    localparam bank_addr_t snd_offset = 22'h02_0000;

    // Header bytes are never written to SDRAM
    localparam int header_len = 32;
    localparam logic [hdr_aw-1:0] hdr_dec_addr = 5'h10;  // Decoder flags
    localparam logic [hdr_aw-1:0] hdr_id_addr  = 5'h18;  // Game id

endpackage

`default_nettype wire
